// ==== design/backend_pkg.sv ====
package backend_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and constants
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int NREG       = 32;
    localparam int REG_AW     = 5;
    localparam int ILEN_BYTES = 4;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_MUL,
        OP_BEQ,
        OP_BNE,
        OP_JAL
    } op_e;

    // Source of a stage's result
    typedef enum logic {
        FU_ALU,
        FU_MUL
    } fu_e;

    // ST_SKIP drops wrong-path instructions after a redirect
    typedef enum logic {
        ST_RUN,
        ST_SKIP
    } issue_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // Structs
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        op_e               op;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [XLEN-1:0]   imm;
        logic              use_imm;
    } instr_t;

    typedef struct packed {
        logic              pending;
        fu_e               sel;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   data;
    } stage_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
    } retire_t;

endpackage

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic [backend_pkg::REG_AW-1:0] raddr_a_i,
    input  logic [backend_pkg::REG_AW-1:0] raddr_b_i,
    output logic [backend_pkg::XLEN-1:0]   rdata_a_o,
    output logic [backend_pkg::XLEN-1:0]   rdata_b_o,
    input  logic                           we_i,
    input  logic [backend_pkg::REG_AW-1:0] waddr_i,
    input  logic [backend_pkg::XLEN-1:0]   wdata_i
);
    import backend_pkg::*;

    logic [XLEN-1:0] regs_q [NREG];

    // x0 is cleared by reset and never written
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < NREG; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = regs_q[raddr_a_i];
    assign rdata_b_o = regs_q[raddr_b_i];

endmodule

// ==== design/operand_bypass.sv ====
`timescale 1ns/1ps

module operand_bypass (
    input  logic [backend_pkg::REG_AW-1:0] rs1_i,
    input  logic [backend_pkg::REG_AW-1:0] rs2_i,
    input  logic [backend_pkg::XLEN-1:0]   rf_rs1_i,
    input  logic [backend_pkg::XLEN-1:0]   rf_rs2_i,
    input  backend_pkg::stage_t            ex1_i,
    input  backend_pkg::stage_t            ex2_i,
    input  logic                           ex1_valid_i,
    input  logic                           ex2_valid_i,
    output logic [backend_pkg::XLEN-1:0]   op_a_o,
    output logic [backend_pkg::XLEN-1:0]   op_b_o,
    output logic                           data_hazard_o
);
    import backend_pkg::*;

    logic haz_a;
    logic haz_b;

    // Returns {hazard, value}. EX1 holds the younger result and wins
    function automatic logic [XLEN:0] resolve(
        input logic [REG_AW-1:0] idx,
        input logic [XLEN-1:0]   rf_val,
        input stage_t            ex1,
        input logic              ex1_ok,
        input stage_t            ex2,
        input logic              ex2_ok
    );
        logic hit1;
        logic hit2;
        hit1 = ex1.pending && ex1.rd == idx && idx != '0;
        hit2 = ex2.pending && ex2.rd == idx && idx != '0;
        if (hit1) begin
            return {!ex1_ok, ex1.data};
        end
        if (hit2) begin
            return {!ex2_ok, ex2.data};
        end
        return {1'b0, rf_val};
    endfunction

    assign {haz_a, op_a_o} = resolve(rs1_i, rf_rs1_i, ex1_i, ex1_valid_i, ex2_i, ex2_valid_i);
    assign {haz_b, op_b_o} = resolve(rs2_i, rf_rs2_i, ex1_i, ex1_valid_i, ex2_i, ex2_valid_i);

    assign data_hazard_o = haz_a || haz_b;

endmodule

// ==== design/int_alu.sv ====
`timescale 1ns/1ps

module int_alu (
    input  backend_pkg::instr_t          instr_i,
    input  logic [backend_pkg::XLEN-1:0] op_a_i,
    input  logic [backend_pkg::XLEN-1:0] op_b_i,
    output logic [backend_pkg::XLEN-1:0] result_o,
    output logic [backend_pkg::XLEN-1:0] next_pc_o
);
    import backend_pkg::*;

    logic [XLEN-1:0] opnd_b;
    logic [XLEN-1:0] link_pc;
    logic [XLEN-1:0] target_pc;
    logic            less;
    logic            taken;

    assign opnd_b    = instr_i.use_imm ? instr_i.imm : op_b_i;
    assign link_pc   = instr_i.pc + XLEN'(ILEN_BYTES);
    assign target_pc = instr_i.pc + instr_i.imm;
    assign less      = $signed(op_a_i) < $signed(opnd_b);

    always_comb begin
        result_o = '0;
        taken    = 1'b0;
        case (instr_i.op)
            OP_ADD: result_o = op_a_i + opnd_b;
            OP_SUB: result_o = op_a_i - opnd_b;
            OP_AND: result_o = op_a_i & opnd_b;
            OP_OR:  result_o = op_a_i | opnd_b;
            OP_XOR: result_o = op_a_i ^ opnd_b;
            OP_SLT: result_o = {{(XLEN-1){1'b0}}, less};
            // Branches compare registers, never the immediate
            OP_BEQ: begin
                result_o = link_pc;
                taken    = op_a_i == op_b_i;
            end
            OP_BNE: begin
                result_o = link_pc;
                taken    = op_a_i != op_b_i;
            end
            OP_JAL: begin
                result_o = link_pc;
                taken    = 1'b1;
            end
            default: begin
                // Product comes from the multiplier
                result_o = '0;
            end
        endcase
    end

    assign next_pc_o = taken ? target_pc : link_pc;

endmodule

// ==== design/iter_multiplier.sv ====
`timescale 1ns/1ps

module iter_multiplier (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         start_i,
    input  logic [backend_pkg::XLEN-1:0] op_a_i,
    input  logic [backend_pkg::XLEN-1:0] op_b_i,
    output logic                         busy_o,
    output logic                         done_o,
    output logic [backend_pkg::XLEN-1:0] product_o
);
    import backend_pkg::*;

    logic                    busy_q;
    logic                    done_q;
    logic [$clog2(XLEN)-1:0] count_q;
    logic [XLEN-1:0]         acc_q;
    logic [XLEN-1:0]         mcand_q;
    logic [XLEN-1:0]         mplier_q;

    // Bit 0 is handled at start, so the last bit lands XLEN-1 cycles later
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            count_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                busy_q  <= 1'b1;
                count_q <= 'd1;
            end else if (busy_q) begin
                count_q <= count_q + 1'b1;
                // XLEN is a power of two, all ones marks the last bit
                if (&count_q) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // Shift-add datapath
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            acc_q    <= op_b_i[0] ? op_a_i : '0;
            mcand_q  <= op_a_i << 1;
            mplier_q <= op_b_i >> 1;
        end else if (busy_q) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    // Busy stays up through the done cycle
    assign busy_o    = busy_q || done_q;
    assign done_o    = done_q;
    assign product_o = acc_q;

    a_no_start_on_done: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !(done_o && start_i)
    );

endmodule

// ==== design/issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         instr_valid_i,
    output logic                         instr_ready_o,
    input  backend_pkg::instr_t          instr_i,
    input  logic                         data_hazard_i,
    input  logic                         ex1_free_i,
    input  logic                         mul_busy_i,
    input  logic [backend_pkg::XLEN-1:0] next_pc_i,
    output backend_pkg::instr_t          held_o,
    output logic                         issue_o,
    output logic                         mul_start_o,
    output logic                         redirect_valid_o,
    output logic [backend_pkg::XLEN-1:0] redirect_pc_o
);
    import backend_pkg::*;

    logic            held_valid_q;
    instr_t          held_q;
    issue_state_e    state_q;
    logic [XLEN-1:0] expected_pc_q;

    logic pc_match;
    logic is_mul;
    logic struct_hazard;
    logic drop;
    logic take;

    ////////////////////////////////////////////////////////////////////////////
    // Hazard checks
    ////////////////////////////////////////////////////////////////////////////

    assign pc_match      = held_q.pc == expected_pc_q;
    assign is_mul        = held_q.op == OP_MUL;
    assign struct_hazard = !ex1_free_i || (is_mul && mul_busy_i);

    assign issue_o = held_valid_q && pc_match && !data_hazard_i && !struct_hazard;

    // Wrong-path instructions leave regardless of other stalls
    assign drop = held_valid_q && !pc_match;

    assign instr_ready_o = !held_valid_q || issue_o || drop;
    assign take          = instr_valid_i && instr_ready_o;

    assign mul_start_o = issue_o && is_mul;
    assign held_o      = held_q;

    // Only the first mismatch after a run of good instructions redirects
    assign redirect_valid_o = drop && state_q == ST_RUN;
    assign redirect_pc_o    = expected_pc_q;

    ////////////////////////////////////////////////////////////////////////////
    // Decode/issue register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            held_valid_q <= 1'b0;
        end else if (take) begin
            held_valid_q <= 1'b1;
        end else if (issue_o || drop) begin
            held_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            held_q <= instr_i;
        end
    end

    // Redirect FSM and expected PC
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q       <= ST_RUN;
            expected_pc_q <= RESET_PC;
        end else begin
            if (redirect_valid_o) begin
                state_q <= ST_SKIP;
            end else if (issue_o) begin
                state_q <= ST_RUN;
            end
            if (issue_o) begin
                expected_pc_q <= next_pc_i;
            end
        end
    end

    a_issue_no_redirect: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !(issue_o && redirect_valid_o)
    );

    // Multiplier busy covers its done cycle, so starts never overlap
    a_mul_start_idle: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !(mul_start_o && mul_busy_i)
    );

endmodule

// ==== design/ex_pipeline.sv ====
`timescale 1ns/1ps

module ex_pipeline (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           issue_i,
    input  backend_pkg::instr_t            held_i,
    input  logic [backend_pkg::XLEN-1:0]   alu_result_i,
    input  logic                           mul_done_i,
    input  logic [backend_pkg::XLEN-1:0]   mul_product_i,
    output backend_pkg::stage_t            ex1_o,
    output backend_pkg::stage_t            ex2_o,
    output logic                           ex1_valid_o,
    output logic                           ex2_valid_o,
    output logic                           ex1_free_o,
    output logic                           wr_en_o,
    output logic [backend_pkg::REG_AW-1:0] wr_addr_o,
    output logic [backend_pkg::XLEN-1:0]   wr_data_o,
    output logic                           retire_valid_o,
    output backend_pkg::retire_t           retire_o
);
    import backend_pkg::*;

    stage_t ex1_q;
    stage_t ex1_d;
    stage_t ex2_q;
    stage_t ex2_d;
    logic   ex2_done;
    logic   advance;

    // Data field is valid once the stage is marked as ALU
    assign ex1_valid_o = ex1_q.sel == FU_ALU;
    assign ex2_valid_o = ex2_q.sel == FU_ALU;

    assign ex2_done   = ex2_q.pending && ex2_valid_o;
    assign advance    = ex1_q.pending && (!ex2_q.pending || ex2_done);
    assign ex1_free_o = !ex1_q.pending || advance;

    ////////////////////////////////////////////////////////////////////////////
    // Stage update
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        ex1_d = ex1_q;
        ex2_d = ex2_q;

        // At most one stage waits on the multiplier
        if (mul_done_i) begin
            if (ex2_q.pending && ex2_q.sel == FU_MUL) begin
                ex2_d.data = mul_product_i;
                ex2_d.sel  = FU_ALU;
            end else if (ex1_q.pending && ex1_q.sel == FU_MUL) begin
                ex1_d.data = mul_product_i;
                ex1_d.sel  = FU_ALU;
            end
        end

        if (ex2_done) begin
            ex2_d.pending = 1'b0;
        end

        if (advance) begin
            ex2_d         = ex1_d;
            ex1_d.pending = 1'b0;
        end

        if (issue_i) begin
            ex1_d.pending = 1'b1;
            ex1_d.sel     = (held_i.op == OP_MUL) ? FU_MUL : FU_ALU;
            ex1_d.rd      = held_i.rd;
            ex1_d.pc      = held_i.pc;
            ex1_d.data    = alu_result_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ex1_q.pending <= 1'b0;
            ex1_q.sel     <= FU_ALU;
            ex2_q.pending <= 1'b0;
            ex2_q.sel     <= FU_ALU;
        end else begin
            ex1_q <= ex1_d;
            ex2_q <= ex2_d;
        end
    end

    assign ex1_o = ex1_q;
    assign ex2_o = ex2_q;

    // Write-back and retire from EX2
    assign wr_en_o        = ex2_done;
    assign wr_addr_o      = ex2_q.rd;
    assign wr_data_o      = ex2_q.data;
    assign retire_valid_o = ex2_done;
    assign retire_o.pc    = ex2_q.pc;
    assign retire_o.rd    = ex2_q.rd;
    assign retire_o.data  = ex2_q.data;

    a_retire_pending: assert property (
        @(posedge clk_i) disable iff (!rst_ni) retire_valid_o |-> ex2_q.pending
    );

endmodule

// ==== design/exec_backend.sv ====
`timescale 1ns/1ps

module exec_backend (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         instr_valid_i,
    output logic                         instr_ready_o,
    input  backend_pkg::instr_t          instr_i,
    output logic                         redirect_valid_o,
    output logic [backend_pkg::XLEN-1:0] redirect_pc_o,
    output logic                         retire_valid_o,
    output backend_pkg::retire_t         retire_o
);
    import backend_pkg::*;

    instr_t            held;
    stage_t            ex1;
    stage_t            ex2;
    logic              issue;
    logic              data_hazard;
    logic              ex1_free;
    logic              ex1_valid;
    logic              ex2_valid;
    logic              mul_start;
    logic              mul_busy;
    logic              mul_done;
    logic [XLEN-1:0]   mul_product;
    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;
    logic [XLEN-1:0]   rf_rs1;
    logic [XLEN-1:0]   rf_rs2;
    logic [XLEN-1:0]   alu_result;
    logic [XLEN-1:0]   next_pc;
    logic              wr_en;
    logic [REG_AW-1:0] wr_addr;
    logic [XLEN-1:0]   wr_data;

    issue_ctrl u_issue (
        .clk_i, .rst_ni, .instr_valid_i, .instr_ready_o, .instr_i,
        .data_hazard_i (data_hazard), .ex1_free_i (ex1_free), .mul_busy_i (mul_busy),
        .next_pc_i (next_pc), .held_o (held), .issue_o (issue), .mul_start_o (mul_start),
        .redirect_valid_o, .redirect_pc_o
    );

    operand_bypass u_bypass (
        .rs1_i (held.rs1), .rs2_i (held.rs2), .rf_rs1_i (rf_rs1), .rf_rs2_i (rf_rs2),
        .ex1_i (ex1), .ex2_i (ex2), .ex1_valid_i (ex1_valid), .ex2_valid_i (ex2_valid),
        .op_a_o (op_a), .op_b_o (op_b), .data_hazard_o (data_hazard)
    );

    int_alu u_alu (
        .instr_i (held), .op_a_i (op_a), .op_b_i (op_b),
        .result_o (alu_result), .next_pc_o (next_pc)
    );

    iter_multiplier u_mul (
        .clk_i, .rst_ni, .start_i (mul_start), .op_a_i (op_a), .op_b_i (op_b),
        .busy_o (mul_busy), .done_o (mul_done), .product_o (mul_product)
    );

    ex_pipeline u_ex (
        .clk_i, .rst_ni, .issue_i (issue), .held_i (held), .alu_result_i (alu_result),
        .mul_done_i (mul_done), .mul_product_i (mul_product), .ex1_o (ex1), .ex2_o (ex2),
        .ex1_valid_o (ex1_valid), .ex2_valid_o (ex2_valid), .ex1_free_o (ex1_free),
        .wr_en_o (wr_en), .wr_addr_o (wr_addr), .wr_data_o (wr_data),
        .retire_valid_o, .retire_o
    );

    reg_file u_rf (
        .clk_i, .rst_ni, .raddr_a_i (held.rs1), .raddr_b_i (held.rs2),
        .rdata_a_o (rf_rs1), .rdata_b_o (rf_rs2),
        .we_i (wr_en), .waddr_i (wr_addr), .wdata_i (wr_data)
    );

endmodule

// ==== verification/backend_tb.sv ====
`timescale 1ns/1ps

module backend_tb;
    import backend_pkg::*;

    localparam int N_ALU          = 40;
    localparam int N_MUL          = 6;
    // ALU chain, multiplies with their two adds, branches with fillers and the x0 test
    localparam int TOTAL_INSTR    = N_ALU + (N_MUL + 2) + 12 + 6;
    localparam int TIMEOUT_CYCLES = TOTAL_INSTR * (XLEN + 8) + 100;

    localparam logic [REG_AW-1:0] X0 = '0;

    logic            clk_i;
    logic            rst_ni;
    logic            instr_valid_i;
    logic            instr_ready_o;
    instr_t          instr_i;
    logic            redirect_valid_o;
    logic [XLEN-1:0] redirect_pc_o;
    logic            retire_valid_o;
    retire_t         retire_o;

    // Program memory, reference state and expected event queues
    instr_t          prog [256];
    logic [XLEN-1:0] ref_regs [NREG];
    logic [XLEN-1:0] arch_pc;
    retire_t         exp_q [$];
    logic [XLEN-1:0] redir_q [$];
    logic [31:0]     lfsr_q;
    int              errors;
    int              retired;
    int              cycles;

    exec_backend UUT (
        .clk_i, .rst_ni, .instr_valid_i, .instr_ready_o, .instr_i,
        .redirect_valid_o, .redirect_pc_o, .retire_valid_o, .retire_o
    );

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    function automatic logic [REG_AW-1:0] rand_reg();
        logic [REG_AW-1:0] r;
        r = REG_AW'(rand_bits(REG_AW));
        return (r == X0) ? REG_AW'(1) : r;
    endfunction

    // Random register other than the given one
    function automatic logic [REG_AW-1:0] rand_reg_except(input logic [REG_AW-1:0] x);
        logic [REG_AW-1:0] r;
        r = rand_reg();
        if (r == x) begin
            r = (x == REG_AW'(1)) ? REG_AW'(2) : REG_AW'(1);
        end
        return r;
    endfunction

    function automatic op_e pick_alu_op(input logic [2:0] k);
        case (k)
            3'd0: return OP_ADD;
            3'd1: return OP_SUB;
            3'd2: return OP_AND;
            3'd3: return OP_OR;
            3'd4: return OP_XOR;
            default: return OP_SLT;
        endcase
    endfunction

    // Place one instruction at the architectural PC and execute it on the model
    task automatic emit(input op_e op, input logic [REG_AW-1:0] rd, input logic [REG_AW-1:0] rs1,
                        input logic [REG_AW-1:0] rs2, input logic [XLEN-1:0] imm,
                        input logic use_imm);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic [XLEN-1:0] next;
        logic [XLEN-1:0] p;
        logic            taken;
        retire_t         r;
        a     = ref_regs[rs1];
        b     = use_imm ? imm : ref_regs[rs2];
        taken = 1'b0;
        res   = arch_pc + XLEN'(ILEN_BYTES);
        case (op)
            OP_ADD: res = a + b;
            OP_SUB: res = a - b;
            OP_AND: res = a & b;
            OP_OR:  res = a | b;
            OP_XOR: res = a ^ b;
            OP_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_MUL: res = a * ref_regs[rs2];
            OP_BEQ: taken = a == ref_regs[rs2];
            OP_BNE: taken = a != ref_regs[rs2];
            default: taken = 1'b1;
        endcase
        next = taken ? arch_pc + imm : arch_pc + XLEN'(ILEN_BYTES);
        prog[arch_pc[9:2]] = '{pc: arch_pc, op: op, rd: rd, rs1: rs1, rs2: rs2,
                              imm: imm, use_imm: use_imm};
        r.pc   = arch_pc;
        r.rd   = rd;
        r.data = res;
        exp_q.push_back(r);
        if (rd != X0) begin
            ref_regs[rd] = res;
        end
        if (taken) begin
            redir_q.push_back(next);
            // Skipped slots hold wrong-path instructions
            for (p = arch_pc + XLEN'(ILEN_BYTES); p < next; p = p + XLEN'(ILEN_BYTES)) begin
                prog[p[9:2]] = '{pc: p, op: OP_XOR, rd: 5'd30, rs1: 5'd30, rs2: X0,
                                imm: 32'hbad0_0bad, use_imm: 1'b1};
            end
        end
        arch_pc = next;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Monitor and front-end model
    ////////////////////////////////////////////////////////////////////////////

    task automatic compare_retire();
        retire_t e;
        retired++;
        assert (exp_q.size() != 0) else begin
            errors++;
            $display("Unexpected retire of pc %h when no instruction was left to retire",
                     retire_o.pc);
        end
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            assert (retire_o == e) else begin
                errors++;
                $display("Error @%0t: retire pc %h rd %0d data %h, expected pc %h rd %0d data %h",
                         $time, retire_o.pc, retire_o.rd, retire_o.data, e.pc, e.rd, e.data);
            end
        end
    endtask

    task automatic match_redirect();
        logic [XLEN-1:0] e;
        assert (redir_q.size() != 0) else begin
            errors++;
            $display("Unexpected redirect to %h with no taken branch outstanding",
                     redirect_pc_o);
        end
        if (redir_q.size() != 0) begin
            e = redir_q.pop_front();
            assert (redirect_pc_o == e) else begin
                errors++;
                $display("Error @%0t: redirect to %h, expected %h", $time, redirect_pc_o, e);
            end
        end
    endtask

    // Feed the program at sequential PCs and follow redirects until all retire
    task automatic run_program(input logic [XLEN-1:0] start_pc, input logic [XLEN-1:0] end_pc);
        logic [XLEN-1:0] fpc;
        fpc = start_pc;
        while (fpc < end_pc || exp_q.size() != 0) begin
            @(negedge clk_i);
            instr_valid_i = fpc < end_pc;
            instr_i       = prog[fpc[9:2]];
            // Outputs depend only on state, so they hold until the next rising edge
            if (retire_valid_o) begin
                compare_retire();
            end
            if (redirect_valid_o) begin
                match_redirect();
                fpc = redirect_pc_o;
            end else if (instr_valid_i && instr_ready_o) begin
                fpc = fpc + XLEN'(ILEN_BYTES);
            end
        end
        assert (redir_q.size() == 0) else begin
            errors++;
            $display("A taken branch finished without its redirect to %h", redir_q[0]);
            redir_q.delete();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_state();
        @(negedge clk_i);
        assert (instr_ready_o == 1'b1) else begin
            errors++;
            $display("Error @%0t: instr_ready_o is low after reset", $time);
        end
        assert (!redirect_valid_o && !retire_valid_o) else begin
            errors++;
            $display("Error @%0t: redirect or retire pulse right after reset", $time);
        end
    endtask

    task automatic alu_chain();
        logic [XLEN-1:0]   start;
        logic [REG_AW-1:0] prev;
        logic [REG_AW-1:0] prev2;
        logic [REG_AW-1:0] rd;
        start = arch_pc;
        prev  = X0;
        prev2 = X0;
        // rs1 hits EX1 and rs2 hits EX2
        for (int i = 0; i < N_ALU; i++) begin
            rd = rand_reg();
            emit(pick_alu_op(3'(rand_bits(3))), rd, prev, prev2, rand_bits(XLEN),
                 1'(rand_bits(1)));
            prev2 = prev;
            prev  = rd;
        end
        run_program(start, arch_pc);
    endtask

    task automatic mul_ops();
        logic [XLEN-1:0]   start;
        logic [REG_AW-1:0] prev;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] src;
        start = arch_pc;
        prev  = rand_reg();
        emit(OP_ADD, prev, X0, X0, rand_bits(XLEN), 1'b1);
        // Odd multiplies avoid the previous result, so only the busy multiplier stalls them
        for (int i = 0; i < N_MUL; i++) begin
            rd  = rand_reg();
            src = (i % 2 == 1) ? rand_reg_except(prev) : prev;
            emit(OP_MUL, rd, src, rand_reg_except(prev), '0, 1'b0);
            prev = rd;
        end
        emit(OP_ADD, rand_reg(), prev, X0, rand_bits(XLEN), 1'b1);
        run_program(start, arch_pc);
    endtask

    task automatic branch_redirect();
        logic [XLEN-1:0]   start;
        logic [REG_AW-1:0] r;
        logic [REG_AW-1:0] j;
        start = arch_pc;
        r     = rand_reg();
        j     = (r == 5'd7) ? 5'd9 : 5'd7;
        emit(OP_ADD, r, X0, X0, rand_bits(XLEN), 1'b1);
        emit(OP_BEQ, X0, r, r, 32'd12, 1'b0);
        emit(OP_BNE, X0, r, r, 32'd12, 1'b0);
        emit(OP_JAL, j, X0, X0, 32'd16, 1'b0);
        emit(OP_ADD, rand_reg(), j, X0, 32'd0, 1'b1);
        emit(OP_BEQ, X0, r, j, 32'd12, 1'b0);
        emit(OP_ADD, rand_reg(), r, j, 32'd0, 1'b0);
        run_program(start, arch_pc);
    endtask

    task automatic zero_reg();
        logic [XLEN-1:0]   start;
        logic [REG_AW-1:0] r;
        start = arch_pc;
        r     = rand_reg();
        emit(OP_ADD, r, X0, X0, rand_bits(XLEN), 1'b1);
        emit(OP_ADD, X0, r, X0, rand_bits(XLEN), 1'b1);
        emit(OP_ADD, rand_reg(), X0, X0, 32'd0, 1'b0);
        emit(OP_OR, rand_reg(), X0, X0, rand_bits(XLEN), 1'b1);
        emit(OP_MUL, X0, r, r, '0, 1'b0);
        emit(OP_ADD, rand_reg(), X0, r, 32'd0, 1'b0);
        run_program(start, arch_pc);
    endtask

    initial begin
        clk_i         = 1'b0;
        rst_ni        = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        lfsr_q        = 32'hfb6c;
        arch_pc       = RESET_PC;
        errors        = 0;
        retired       = 0;
        cycles        = 0;
        for (int i = 0; i < NREG; i++) begin
            ref_regs[i] = '0;
        end
        repeat (2) @(negedge clk_i);
        rst_ni = 1'b1;

        reset_state();
        alu_chain();
        mul_ops();
        branch_redirect();
        zero_reg();

        $display("Summary: %0d errors, %0d instructions retired", errors, retired);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
design/backend_pkg.sv
design/reg_file.sv
design/operand_bypass.sv
design/int_alu.sv
design/iter_multiplier.sv
design/issue_ctrl.sv
design/ex_pipeline.sv
design/exec_backend.sv
verification/backend_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the backend testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module backend_tb -o backend_sim

out=$(./obj_dir/backend_sim)
echo "$out"

# Fails the script unless the pass line is present
echo "$out" | grep -qx "TEST PASSED"
